/* common/exec_pkg.sv */
package exec_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int mem_addr_w = 8;
  localparam int div_latency_c = xlen; // One quotient bit per iteration.

  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    alu_pass_b = 4'd10, // LUI.
    alu_add_pc = 4'd11  // AUIPC.
  } alu_op_t;

  // Bit 0 marks a signed divide, bit 1 selects the remainder.
  typedef enum logic [3:0] {
    div_divu = 4'b0000,
    div_div  = 4'b0001,
    div_remu = 4'b0010,
    div_rem  = 4'b0011
  } div_op_t;

  typedef enum logic [2:0] {
    lsu_lb  = 3'b000,
    lsu_lh  = 3'b001,
    lsu_lw  = 3'b010,
    lsu_lbu = 3'b100,
    lsu_lhu = 3'b101
  } lsu_op_t;

  typedef union packed {
    alu_op_t alu;
    div_op_t div;
  } exe_op_u;

endpackage

/* execute/int_alu.sv */
`timescale 1ns/1ps

module int_alu (
  input  logic [exec_pkg::xlen-1:0] rdata1,
  input  logic [exec_pkg::xlen-1:0] rdata2,
  input  logic [exec_pkg::xlen-1:0] imm,
  input  logic [exec_pkg::xlen-1:0] pc,
  input  logic                      sel_imm,
  input  exec_pkg::alu_op_t         alu_op,
  output logic [exec_pkg::xlen-1:0] result
);
  import exec_pkg::*;

  logic [xlen-1:0] opb;
  logic [4:0]      shamt;

  assign opb   = sel_imm ? imm : rdata2;
  assign shamt = opb[4:0];

  always_comb begin
    case (alu_op)
      alu_add: begin
        result = rdata1 + opb;
      end
      alu_sub: begin
        result = rdata1 - opb;
      end
      alu_sll: begin
        result = rdata1 << shamt;
      end
      alu_slt: begin
        result = {{(xlen-1){1'b0}}, $signed(rdata1) < $signed(opb)};
      end
      alu_sltu: begin
        result = {{(xlen-1){1'b0}}, rdata1 < opb};
      end
      alu_xor: begin
        result = rdata1 ^ opb;
      end
      alu_srl: begin
        result = rdata1 >> shamt;
      end
      alu_sra: begin
        result = $signed(rdata1) >>> shamt;
      end
      alu_or: begin
        result = rdata1 | opb;
      end
      alu_and: begin
        result = rdata1 & opb;
      end
      alu_pass_b: result = opb;
      alu_add_pc: result = pc + opb;
      default: result = '0;
    endcase
  end

endmodule

/* execute/seq_divider.sv */
`timescale 1ns/1ps

module seq_divider (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  exec_pkg::div_op_t         op,
  input  logic [exec_pkg::xlen-1:0] dividend,
  input  logic [exec_pkg::xlen-1:0] divisor,
  output logic                      ready,
  output logic [exec_pkg::xlen-1:0] result
);
  import exec_pkg::*;

  localparam int cnt_w = $clog2(div_latency_c);

  logic             busy;
  logic [cnt_w-1:0] count;
  logic [xlen-1:0]  quo;
  logic [xlen-1:0]  rem;
  logic [xlen-1:0]  dvs;
  logic [xlen-1:0]  dvd_save;
  logic             neg_q;
  logic             neg_r;
  logic             sel_rem;
  logic             div_zero;
  logic             sgn;
  logic [xlen:0]    shifted;
  logic [xlen:0]    diff;

  assign sgn     = op[0];
  assign shifted = {rem, quo[xlen-1]};
  assign diff    = shifted - {1'b0, dvs};

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy  <= 1'b0;
      ready <= 1'b0;
      count <= '0;
    end else begin
      ready <= 1'b0;
      if (start && !busy) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (busy) begin
        count <= count + 1'b1;
        if (count == cnt_w'(div_latency_c - 1)) begin
          busy  <= 1'b0;
          ready <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start && !busy) begin
      rem      <= '0;
      quo      <= (sgn && dividend[xlen-1]) ? -dividend : dividend;
      dvs      <= (sgn && divisor[xlen-1]) ? -divisor : divisor;
      dvd_save <= dividend;
      neg_q    <= sgn & (dividend[xlen-1] ^ divisor[xlen-1]);
      neg_r    <= sgn & dividend[xlen-1]; // Remainder takes the dividend's sign.
      sel_rem  <= op[1];
      div_zero <= (divisor == '0);
    end else if (busy) begin
      if (!diff[xlen]) begin
        rem <= diff[xlen-1:0];
        quo <= {quo[xlen-2:0], 1'b1};
      end else begin
        rem <= shifted[xlen-1:0];
        quo <= {quo[xlen-2:0], 1'b0};
      end
    end
  end

  // Signed overflow yields a quotient magnitude of 2**31 with neg_q low, which is the dividend.
  always_comb begin
    if (div_zero) begin
      result = sel_rem ? dvd_save : '1;
    end else if (sel_rem) begin
      result = neg_r ? -rem : rem;
    end else begin
      result = neg_q ? -quo : quo;
    end
  end

  assert property (@(posedge clk) disable iff (!rst) busy |-> !start);

endmodule

/* execute/lsu_align.sv */
`timescale 1ns/1ps

module lsu_align (
  input  logic [exec_pkg::xlen-1:0] addr,
  input  logic                      store,
  input  exec_pkg::lsu_op_t         lsu_op,
  input  logic [exec_pkg::xlen-1:0] sdata,
  input  logic [exec_pkg::xlen-1:0] rdata,
  output logic [3:0]                byte_en,
  output logic [exec_pkg::xlen-1:0] wdata_lanes,
  output logic [exec_pkg::xlen-1:0] load_data
);
  import exec_pkg::*;

  logic [1:0]  offset;
  logic [1:0]  size;
  logic [7:0]  load_byte;
  logic [15:0] load_half;

  assign offset = addr[1:0];
  assign size   = lsu_op[1:0]; // 0 byte, 1 half, 2 word.

  always_comb begin
    case (size)
      2'b00: begin
        byte_en     = 4'b0001 << offset;
        wdata_lanes = {4{sdata[7:0]}};
      end
      2'b01: begin
        byte_en     = 4'b0011 << {offset[1], 1'b0};
        wdata_lanes = {2{sdata[15:0]}};
      end
      default: begin
        byte_en     = 4'b1111;
        wdata_lanes = sdata;
      end
    endcase
    if (!store) begin
      byte_en = 4'b0000;
    end
  end

  assign load_byte = rdata[8*offset +: 8];
  assign load_half = rdata[16*offset[1] +: 16];

  always_comb begin
    case (lsu_op)
      lsu_lb: begin
        load_data = {{(xlen-8){load_byte[7]}}, load_byte};
      end
      lsu_lbu: begin
        load_data = {{(xlen-8){1'b0}}, load_byte};
      end
      lsu_lh: begin
        load_data = {{(xlen-16){load_half[15]}}, load_half};
      end
      lsu_lhu: begin
        load_data = {{(xlen-16){1'b0}}, load_half};
      end
      default: load_data = rdata;
    endcase
  end

endmodule

/* execute/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              issue_valid,
  input  logic [exec_pkg::xlen-1:0]         pc,
  input  exec_pkg::exe_op_u                 op,
  input  exec_pkg::lsu_op_t                 lsu_op,
  input  logic [exec_pkg::xlen-1:0]         rdata1,
  input  logic [exec_pkg::xlen-1:0]         rdata2,
  input  logic [exec_pkg::xlen-1:0]         imm,
  input  logic [exec_pkg::reg_addr_w-1:0]   waddr,
  input  logic                              sel_imm,
  input  logic                              lui,
  input  logic                              auipc,
  input  logic                              jal,
  input  logic                              division,
  input  logic                              load,
  input  logic                              store,
  input  logic                              clear,
  output logic [exec_pkg::xlen-1:0]         ex_pc,
  output logic [exec_pkg::xlen-1:0]         ex_rdata1,
  output logic [exec_pkg::xlen-1:0]         ex_rdata2,
  output logic [exec_pkg::xlen-1:0]         ex_imm,
  output logic                              ex_sel_imm,
  output exec_pkg::alu_op_t                 alu_op,
  input  logic [exec_pkg::xlen-1:0]         alu_result,
  output logic                              div_start,
  output exec_pkg::div_op_t                 div_op,
  input  logic                              div_ready,
  input  logic [exec_pkg::xlen-1:0]         div_result,
  output logic [exec_pkg::xlen-1:0]         lsu_addr,
  output logic                              lsu_store,
  output exec_pkg::lsu_op_t                 lsu_op_o,
  output logic [exec_pkg::xlen-1:0]         lsu_sdata,
  input  logic [exec_pkg::xlen-1:0]         lsu_load_data,
  output logic                              mem_req,
  input  logic                              mem_ready,
  output logic                              wren,
  output logic [exec_pkg::reg_addr_w-1:0]   wb_addr,
  output logic [exec_pkg::xlen-1:0]         wb_data,
  output logic                              stall
);
  import exec_pkg::*;

  logic                  valid_q;
  logic                  first_q;
  logic                  clear_q;
  logic [xlen-1:0]       pc_q;
  logic [xlen-1:0]       rdata1_q;
  logic [xlen-1:0]       rdata2_q;
  logic [xlen-1:0]       imm_q;
  exe_op_u               op_q;
  lsu_op_t               lsu_op_q;
  logic [reg_addr_w-1:0] waddr_q;
  logic                  sel_imm_q;
  logic                  lui_q;
  logic                  auipc_q;
  logic                  jal_q;
  logic                  division_q;
  logic                  load_q;
  logic                  store_q;
  logic                  live;
  logic                  mem_busy;
  logic                  div_busy;
  logic [xlen-1:0]       wdata;

  always_ff @(posedge clk) begin
    if (!rst) begin
      valid_q <= 1'b0;
      first_q <= 1'b0;
      clear_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= issue_valid;
      first_q <= issue_valid; // High only in the first cycle in the stage.
      clear_q <= clear;
    end else begin
      first_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_q       <= pc;
      op_q       <= op;
      lsu_op_q   <= lsu_op;
      rdata1_q   <= rdata1;
      rdata2_q   <= rdata2;
      imm_q      <= imm;
      waddr_q    <= waddr;
      sel_imm_q  <= sel_imm;
      lui_q      <= lui;
      auipc_q    <= auipc;
      jal_q      <= jal;
      division_q <= division;
      load_q     <= load;
      store_q    <= store;
    end
  end

  assign live     = valid_q & ~clear_q; // A squashed slot starts no unit and never stalls.
  assign mem_busy = live & (load_q | store_q);
  assign div_busy = live & division_q;
  assign stall    = (div_busy & ~div_ready) | (mem_busy & ~mem_ready);

  assign div_start = div_busy & first_q;
  assign mem_req   = mem_busy & first_q;

  // LUI and AUIPC reuse the ALU with the immediate as second operand.
  assign ex_pc      = pc_q;
  assign ex_rdata1  = rdata1_q;
  assign ex_rdata2  = rdata2_q;
  assign ex_imm     = imm_q;
  assign ex_sel_imm = sel_imm_q | lui_q | auipc_q;
  assign alu_op     = auipc_q ? alu_add_pc : (lui_q ? alu_pass_b : op_q.alu);
  assign div_op     = op_q.div;

  assign lsu_addr  = rdata1_q + imm_q;
  assign lsu_store = store_q;
  assign lsu_op_o  = lsu_op_q;
  assign lsu_sdata = rdata2_q;

  always_comb begin
    if (auipc_q | lui_q) begin
      wdata = alu_result;
    end else if (jal_q) begin
      wdata = pc_q + 32'd4; // Link address for JAL and JALR.
    end else if (division_q) begin
      wdata = div_result;
    end else if (load_q) begin
      wdata = lsu_load_data;
    end else begin
      wdata = alu_result;
    end
  end

  // A write fires when the unit that owns the slot reports completion.
  assign wren    = (div_busy ? div_ready : (mem_busy ? mem_ready : live)) & ~store_q &
                   (waddr_q != '0);
  assign wb_addr = waddr_q;
  assign wb_data = wdata;

  assert property (@(posedge clk) disable iff (!rst) stall |-> !wren);
  assert property (@(posedge clk) disable iff (!rst) !(mem_req && div_start));

endmodule

/* rtl/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
  parameter int depth = 256
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            req,
  input  logic                            we,
  input  logic [exec_pkg::mem_addr_w-1:0] addr,
  input  logic [3:0]                      byte_en,
  input  logic [exec_pkg::xlen-1:0]       wdata,
  output logic                            ready,
  output logic [exec_pkg::xlen-1:0]       rdata
);
  import exec_pkg::*;

  logic [xlen-1:0] mem [depth];
  logic            req_d1;
  logic [xlen-1:0] rdata_d1;

  // Two-stage response: ready and rdata arrive two cycles after req.
  always_ff @(posedge clk) begin
    if (!rst) begin
      req_d1 <= 1'b0;
      ready  <= 1'b0;
    end else begin
      req_d1 <= req;
      ready  <= req_d1;
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      if (we) begin
        for (int i = 0; i < xlen/8; i++) begin
          if (byte_en[i]) begin
            mem[addr][8*i +: 8] <= wdata[8*i +: 8];
          end
        end
      end
      rdata_d1 <= mem[addr]; // Old contents on a store cycle.
    end
    rdata <= rdata_d1;
  end

endmodule

/* rtl/exec_top.sv */
`timescale 1ns/1ps

module exec_top #(
  parameter int ram_depth = 256
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            issue_valid,
  input  logic [exec_pkg::xlen-1:0]       pc,
  input  exec_pkg::exe_op_u               op,
  input  exec_pkg::lsu_op_t               lsu_op,
  input  logic [exec_pkg::xlen-1:0]       rdata1,
  input  logic [exec_pkg::xlen-1:0]       rdata2,
  input  logic [exec_pkg::xlen-1:0]       imm,
  input  logic [exec_pkg::reg_addr_w-1:0] waddr,
  input  logic                            sel_imm,
  input  logic                            lui,
  input  logic                            auipc,
  input  logic                            jal,
  input  logic                            division,
  input  logic                            load,
  input  logic                            store,
  input  logic                            clear,
  output logic                            wren,
  output logic [exec_pkg::reg_addr_w-1:0] wb_addr,
  output logic [exec_pkg::xlen-1:0]       wb_data,
  output logic                            stall
);
  import exec_pkg::*;

  logic [xlen-1:0] ex_pc;
  logic [xlen-1:0] ex_rdata1;
  logic [xlen-1:0] ex_rdata2;
  logic [xlen-1:0] ex_imm;
  logic            ex_sel_imm;
  alu_op_t         alu_op;
  logic [xlen-1:0] alu_result;
  logic            div_start;
  div_op_t         div_op;
  logic            div_ready;
  logic [xlen-1:0] div_result;
  logic [xlen-1:0] lsu_addr;
  logic            lsu_store;
  lsu_op_t         lsu_op_w;
  logic [xlen-1:0] lsu_sdata;
  logic [xlen-1:0] lsu_load_data;
  logic [3:0]      byte_en;
  logic [xlen-1:0] wdata_lanes;
  logic            mem_req;
  logic            mem_ready;
  logic [xlen-1:0] mem_rdata;

  execute_stage u_stage (
    .clk(clk), .rst(rst), .issue_valid(issue_valid), .pc(pc), .op(op), .lsu_op(lsu_op),
    .rdata1(rdata1), .rdata2(rdata2), .imm(imm), .waddr(waddr), .sel_imm(sel_imm),
    .lui(lui), .auipc(auipc), .jal(jal), .division(division), .load(load), .store(store),
    .clear(clear), .ex_pc(ex_pc), .ex_rdata1(ex_rdata1), .ex_rdata2(ex_rdata2),
    .ex_imm(ex_imm), .ex_sel_imm(ex_sel_imm), .alu_op(alu_op), .alu_result(alu_result),
    .div_start(div_start), .div_op(div_op), .div_ready(div_ready), .div_result(div_result),
    .lsu_addr(lsu_addr), .lsu_store(lsu_store), .lsu_op_o(lsu_op_w), .lsu_sdata(lsu_sdata),
    .lsu_load_data(lsu_load_data), .mem_req(mem_req), .mem_ready(mem_ready),
    .wren(wren), .wb_addr(wb_addr), .wb_data(wb_data), .stall(stall)
  );

  int_alu u_alu (
    .rdata1(ex_rdata1), .rdata2(ex_rdata2), .imm(ex_imm), .pc(ex_pc),
    .sel_imm(ex_sel_imm), .alu_op(alu_op), .result(alu_result)
  );

  seq_divider u_div (
    .clk(clk), .rst(rst), .start(div_start), .op(div_op), .dividend(ex_rdata1),
    .divisor(ex_rdata2), .ready(div_ready), .result(div_result)
  );

  lsu_align u_lsu (
    .addr(lsu_addr), .store(lsu_store), .lsu_op(lsu_op_w), .sdata(lsu_sdata),
    .rdata(mem_rdata), .byte_en(byte_en), .wdata_lanes(wdata_lanes),
    .load_data(lsu_load_data)
  );

  data_ram #(
    .depth(ram_depth)
  ) u_ram (
    .clk(clk), .rst(rst), .req(mem_req), .we(lsu_store),
    .addr(lsu_addr[mem_addr_w+1:2]), .byte_en(byte_en), .wdata(wdata_lanes),
    .ready(mem_ready), .rdata(mem_rdata)
  );

endmodule

/* verif/tb_exec_table.svh */
`ifndef tb_exec_table_svh
`define tb_exec_table_svh

  localparam int n_rows = 49;

  // Columns are kind, fn, clr, a, b, imm, rd, wr and the expected write data.
  // fn is the ALU or divider code; loads and stores use 0 lb, 1 lh, 2 lw, 4 lbu, 5 lhu.
  // Column a drives both rdata1 and pc.
  localparam row_t table_rows [n_rows] = '{
    '{k_alu, alu_add, 1'b0, 32'h00000005, 32'h00000007, 32'h0, 5'd1, 1'b1, 32'h0000000c},
    '{k_alu, alu_sub, 1'b0, 32'h00000005, 32'h00000007, 32'h0, 5'd2, 1'b1, 32'hfffffffe},
    '{k_alui, alu_sll, 1'b0, 32'h00000003, 32'h0, 32'h00000004, 5'd3, 1'b1, 32'h00000030},
    '{k_alu, alu_slt, 1'b0, 32'hfffffffe, 32'h00000001, 32'h0, 5'd4, 1'b1, 32'h00000001},
    '{k_alu, alu_sltu, 1'b0, 32'hfffffffe, 32'h00000001, 32'h0, 5'd5, 1'b1, 32'h00000000},
    '{k_alui, alu_xor, 1'b0, 32'hf0f0f0f0, 32'h0, 32'h0000ffff, 5'd6, 1'b1, 32'hf0f00f0f},
    '{k_alu, alu_srl, 1'b0, 32'h80000000, 32'h00000024, 32'h0, 5'd7, 1'b1, 32'h08000000},
    '{k_alui, alu_sra, 1'b0, 32'h80000000, 32'h0, 32'h00000004, 5'd8, 1'b1, 32'hf8000000},
    '{k_alu, alu_or, 1'b0, 32'h0f000000, 32'h000000f0, 32'h0, 5'd9, 1'b1, 32'h0f0000f0},
    '{k_alui, alu_and, 1'b0, 32'h12345678, 32'h0, 32'h00000ff0, 5'd10, 1'b1, 32'h00000670},
    '{k_lui, alu_pass_b, 1'b0, 32'h0, 32'h0, 32'h12345000, 5'd11, 1'b1, 32'h12345000},
    '{k_auipc, alu_add_pc, 1'b0, 32'h00001000, 32'h0, 32'h00002000, 5'd12, 1'b1, 32'h00003000},
    '{k_jal, alu_add, 1'b0, 32'h00001008, 32'h0, 32'h0, 5'd13, 1'b1, 32'h0000100c},
    '{k_alu, alu_add, 1'b0, 32'h00000001, 32'h00000001, 32'h0, 5'd0, 1'b0, 32'h0},
    '{k_div, div_div, 1'b0, 32'hfffffff9, 32'h00000002, 32'h0, 5'd14, 1'b1, 32'hfffffffd},
    '{k_div, div_rem, 1'b0, 32'hfffffff9, 32'h00000002, 32'h0, 5'd15, 1'b1, 32'hffffffff},
    '{k_div, div_divu, 1'b0, 32'hfffffff9, 32'h00000002, 32'h0, 5'd16, 1'b1, 32'h7ffffffc},
    '{k_div, div_remu, 1'b0, 32'hfffffff9, 32'h00000002, 32'h0, 5'd17, 1'b1, 32'h00000001},
    '{k_div, div_div, 1'b0, 32'h00000064, 32'hfffffff9, 32'h0, 5'd18, 1'b1, 32'hfffffff2},
    '{k_div, div_rem, 1'b0, 32'h00000064, 32'hfffffff9, 32'h0, 5'd19, 1'b1, 32'h00000002},
    '{k_div, div_div, 1'b0, 32'h00000123, 32'h0, 32'h0, 5'd20, 1'b1, 32'hffffffff},
    '{k_div, div_remu, 1'b0, 32'h00000123, 32'h0, 32'h0, 5'd21, 1'b1, 32'h00000123},
    '{k_div, div_div, 1'b0, 32'h80000000, 32'hffffffff, 32'h0, 5'd22, 1'b1, 32'h80000000},
    '{k_div, div_rem, 1'b0, 32'h80000000, 32'hffffffff, 32'h0, 5'd23, 1'b1, 32'h00000000},
    '{k_div, div_divu, 1'b0, 32'h80000000, 32'hffffffff, 32'h0, 5'd24, 1'b1, 32'h00000000},
    '{k_alu, alu_add, 1'b1, 32'h00000001, 32'h00000002, 32'h0, 5'd25, 1'b0, 32'h0},
    '{k_alu, alu_add, 1'b0, 32'h00000003, 32'h00000004, 32'h0, 5'd25, 1'b1, 32'h00000007},
    '{k_div, div_div, 1'b1, 32'h00000064, 32'h00000007, 32'h0, 5'd26, 1'b0, 32'h0},
    '{k_div, div_divu, 1'b0, 32'h00000064, 32'h00000007, 32'h0, 5'd26, 1'b1, 32'h0000000e},
    '{k_store, 4'd2, 1'b0, 32'h00000100, 32'h8899aabb, 32'h0, 5'd9, 1'b0, 32'h0},
    '{k_store, 4'd0, 1'b0, 32'h00000100, 32'h000000c5, 32'h00000001, 5'd9, 1'b0, 32'h0},
    '{k_store, 4'd1, 1'b0, 32'h00000100, 32'h00007e11, 32'h00000002, 5'd9, 1'b0, 32'h0},
    '{k_load, 4'd2, 1'b0, 32'h00000100, 32'h0, 32'h0, 5'd1, 1'b1, 32'h7e11c5bb},
    '{k_load, 4'd0, 1'b0, 32'h00000100, 32'h0, 32'h0, 5'd2, 1'b1, 32'hffffffbb},
    '{k_load, 4'd0, 1'b0, 32'h00000100, 32'h0, 32'h00000001, 5'd3, 1'b1, 32'hffffffc5},
    '{k_load, 4'd0, 1'b0, 32'h00000100, 32'h0, 32'h00000002, 5'd4, 1'b1, 32'h00000011},
    '{k_load, 4'd0, 1'b0, 32'h00000100, 32'h0, 32'h00000003, 5'd5, 1'b1, 32'h0000007e},
    '{k_load, 4'd4, 1'b0, 32'h00000100, 32'h0, 32'h0, 5'd6, 1'b1, 32'h000000bb},
    '{k_load, 4'd4, 1'b0, 32'h00000100, 32'h0, 32'h00000001, 5'd7, 1'b1, 32'h000000c5},
    '{k_load, 4'd4, 1'b0, 32'h00000100, 32'h0, 32'h00000002, 5'd8, 1'b1, 32'h00000011},
    '{k_load, 4'd4, 1'b0, 32'h00000100, 32'h0, 32'h00000003, 5'd10, 1'b1, 32'h0000007e},
    '{k_load, 4'd1, 1'b0, 32'h00000100, 32'h0, 32'h0, 5'd11, 1'b1, 32'hffffc5bb},
    '{k_load, 4'd1, 1'b0, 32'h00000100, 32'h0, 32'h00000002, 5'd12, 1'b1, 32'h00007e11},
    '{k_load, 4'd5, 1'b0, 32'h00000100, 32'h0, 32'h0, 5'd13, 1'b1, 32'h0000c5bb},
    '{k_load, 4'd5, 1'b0, 32'h00000100, 32'h0, 32'h00000002, 5'd14, 1'b1, 32'h00007e11},
    '{k_store, 4'd1, 1'b0, 32'h00000104, 32'h12349abc, 32'h0, 5'd9, 1'b0, 32'h0},
    '{k_load, 4'd1, 1'b0, 32'h00000104, 32'h0, 32'h0, 5'd15, 1'b1, 32'hffff9abc},
    '{k_load, 4'd5, 1'b0, 32'h00000104, 32'h0, 32'h0, 5'd16, 1'b1, 32'h00009abc},
    '{k_load, 4'd4, 1'b0, 32'h000000fc, 32'h0, 32'h00000007, 5'd17, 1'b1, 32'h0000007e}
  };

`endif

/* verif/tb_exec.sv */
`timescale 1ns/1ps

module tb_exec;
  import exec_pkg::*;

  typedef enum logic [2:0] {
    k_alu, k_alui, k_lui, k_auipc, k_jal, k_div, k_load, k_store
  } kind_t;

  typedef struct packed {
    kind_t                 kind;
    logic [3:0]            fn;
    logic                  clr;
    logic [xlen-1:0]       a;
    logic [xlen-1:0]       b;
    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] rd;
    logic                  wr;
    logic [xlen-1:0]       exp_data;
  } row_t;

  `include "tb_exec_table.svh"

  localparam int n_rand = 8;
  localparam int limit_cycles = (n_rows + n_rand) * (div_latency_c + 8);

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  issue_valid;
  logic [xlen-1:0]       pc;
  exe_op_u               op;
  lsu_op_t               lsu_op;
  logic [xlen-1:0]       rdata1;
  logic [xlen-1:0]       rdata2;
  logic [xlen-1:0]       imm;
  logic [reg_addr_w-1:0] waddr;
  logic                  sel_imm;
  logic                  lui;
  logic                  auipc;
  logic                  jal;
  logic                  division;
  logic                  load;
  logic                  store;
  logic                  clear;
  logic                  wren;
  logic [reg_addr_w-1:0] wb_addr;
  logic [xlen-1:0]       wb_data;
  logic                  stall;

  row_t                  rows_q[$];
  logic [xlen-1:0]       exp_addr_q[$];
  logic [xlen-1:0]       exp_data_q[$];
  int                    exp_cycle_q[$]; // A value of -1 means the write closes a stall.
  int                    cycle = 0;
  int                    checks = 0;
  int                    errors = 0;
  logic                  stall_prev = 1'b0;

  exec_top #(
    .ram_depth(256)
  ) dut (
    .clk(clk), .rst(rst), .issue_valid(issue_valid), .pc(pc), .op(op), .lsu_op(lsu_op),
    .rdata1(rdata1), .rdata2(rdata2), .imm(imm), .waddr(waddr), .sel_imm(sel_imm),
    .lui(lui), .auipc(auipc), .jal(jal), .division(division), .load(load), .store(store),
    .clear(clear), .wren(wren), .wb_addr(wb_addr), .wb_data(wb_data), .stall(stall)
  );

  always #50 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic drive_idle();
    issue_valid <= 1'b0;
    pc          <= '0;
    op          <= exe_op_u'(4'd0);
    lsu_op      <= lsu_lw;
    rdata1      <= '0;
    rdata2      <= '0;
    imm         <= '0;
    waddr       <= '0;
    sel_imm     <= 1'b0;
    lui         <= 1'b0;
    auipc       <= 1'b0;
    jal         <= 1'b0;
    division    <= 1'b0;
    load        <= 1'b0;
    store       <= 1'b0;
    clear       <= 1'b0;
  endtask

  task automatic drive_row(input row_t r);
    issue_valid <= 1'b1;
    pc          <= r.a;
    op          <= exe_op_u'(r.fn);
    lsu_op      <= lsu_op_t'(r.fn[2:0]);
    rdata1      <= r.a;
    rdata2      <= r.b;
    imm         <= r.imm;
    waddr       <= r.rd;
    sel_imm     <= (r.kind == k_alui);
    lui         <= (r.kind == k_lui);
    auipc       <= (r.kind == k_auipc);
    jal         <= (r.kind == k_jal);
    division    <= (r.kind == k_div);
    load        <= (r.kind == k_load);
    store       <= (r.kind == k_store);
    clear       <= r.clr;
  endtask

  // Called at the edge where the stage takes the row in.
  task automatic note_capture(input row_t r);
    int lat;
    if (r.wr) begin
      lat = (r.kind == k_load) ? 3 : ((r.kind == k_div) ? -1 : 1);
      exp_addr_q.push_back(32'(r.rd));
      exp_data_q.push_back(r.exp_data);
      exp_cycle_q.push_back((lat < 0) ? -1 : cycle + lat);
    end
  endtask

  task automatic add_random_rows();
    row_t        r;
    logic [31:0] seed;
    seed = 32'h8bd3;
    for (int j = 0; j < n_rand; j++) begin
      seed       = lcg_next(seed);
      r.a        = seed;
      seed       = lcg_next(seed);
      r.b        = seed;
      r.imm      = seed;
      r.kind     = (j % 2 == 0) ? k_alu : k_alui;
      r.fn       = (j % 2 == 0) ? alu_add : alu_xor;
      r.clr      = 1'b0;
      r.rd       = 5'(j + 1);
      r.wr       = 1'b1;
      r.exp_data = (j % 2 == 0) ? r.a + r.b : r.a ^ r.b;
      rows_q.push_back(r);
    end
  endtask

  always @(negedge clk) begin
    int want_cycle;
    if (rst && wren) begin
      if (exp_data_q.size() == 0) begin
        errors++;
        $display("Unexpected write to x%0d at %0t with no write pending.", wb_addr, $time);
      end else begin
        want_cycle = exp_cycle_q.pop_front();
        check_value("wb_addr", 32'(wb_addr), exp_addr_q.pop_front());
        check_value("wb_data", wb_data, exp_data_q.pop_front());
        check_value("stall", 32'(stall), 32'h0);
        if (want_cycle < 0) begin
          check_value("stall before write", 32'(stall_prev), 32'h1);
        end else begin
          check_value("write cycle", cycle, want_cycle);
        end
      end
    end
    stall_prev = stall;
  end

  initial begin
    drive_idle();
    rst <= 1'b0;
    foreach (table_rows[i]) rows_q.push_back(table_rows[i]);
    add_random_rows();
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_value("wren", 32'(wren), 32'h0);
    check_value("stall", 32'(stall), 32'h0);
    @(posedge clk);
    rst <= 1'b1;
    foreach (rows_q[i]) begin
      drive_row(rows_q[i]);
      @(posedge clk);
      while (stall) @(posedge clk); // The issue side holds the row while the stage stalls.
      note_capture(rows_q[i]);
    end
    drive_idle();
    @(posedge clk);
    while (stall) @(posedge clk);
    repeat (4) @(posedge clk);
    if (exp_data_q.size() != 0) begin
      errors++;
      $display("%0d expected writes never arrived.", exp_data_q.size());
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles.", limit_cycles);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* exec_subsys.f */
+incdir+verif
common/exec_pkg.sv
execute/int_alu.sv
execute/seq_divider.sv
execute/lsu_align.sv
execute/execute_stage.sv
rtl/data_ram.sv
rtl/exec_top.sv
verif/tb_exec.sv
